// ==== compile.f ====
source/ising_pkg.sv
source/bp_pipe.sv
source/monitor_ctrl.sv
source/row_counter.sv
source/spin_cache.sv
source/partial_energy_calc.sv
source/energy_accumulator.sv
source/energy_monitor.sv
tests/tb_clock.sv
tests/tb_energy_monitor.sv

// ==== run.sh ====
#!/bin/sh
# build and run the energy monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_energy_monitor -o tb_energy_monitor

./obj_dir/tb_energy_monitor | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/tb_energy_monitor.sv ====
// testbench for energy_monitor, inputs change on the falling clock edge
// readies are read 1 ns after the falling edge, when en_i has settled
// expected energies come from a reference model of the Ising energy rule
// one computation is in flight at a time, so the expected queue holds one entry

`timescale 1ns/1ps
`default_nettype none

module tb_energy_monitor;

    localparam int TIMEOUT_CYCLES = 4000; // ~12 runs of up to 20 beats plus stalls, wide margin

    typedef struct packed {
        logic signed [ising_pkg::TOTAL_E_BIT-1:0] energy;
        logic                                     ovf;
    } expect_t;

    logic                                     clk;
    logic                                     arst_n_i;
    logic                                     en_i;
    logic                                     config_valid_i;
    logic [ising_pkg::IDX_BIT-1:0]            config_counter_i;
    logic                                     config_ready_o;
    logic                                     spin_valid_i;
    logic [ising_pkg::NUM_SPINS-1:0]          spin_i;
    logic                                     spin_ready_o;
    logic                                     weight_valid_i;
    ising_pkg::weight_word_t                  weight_i;
    logic                                     weight_ready_o;
    logic                                     energy_valid_o;
    logic signed [ising_pkg::TOTAL_E_BIT-1:0] energy_o;
    logic                                     energy_ready_i;
    logic                                     accum_overflow_o;

    integer                          seed = 32'hf087_a12b;
    int                              err_cnt = 0;
    int                              test_cnt = 0;
    int                              cycle_cnt = 0;
    int                              wgt_sent = 0;   // weight beats taken at the ports
    int                              err_before;
    logic                            last_tag = 1'b0;    // beat on the port is the last row
    logic                            extra_phase = 1'b0; // surplus beat must wait
    ising_pkg::weight_word_t         w_mem [ising_pkg::NUM_SPINS];
    ising_pkg::weight_word_t         b0;
    ising_pkg::weight_word_t         b1;
    logic [ising_pkg::NUM_SPINS-1:0] spin_vec;
    expect_t                         exp_q [$];
    expect_t                         exp_head = '0;
    logic signed [ising_pkg::TOTAL_E_BIT-1:0] exp_energy;
    logic                                     exp_ovf;

    assign {exp_energy, exp_ovf} = exp_head;

    tb_clock u_clock (.clk_o(clk));

    energy_monitor dut_i (
        .clk_i(clk), .arst_n_i, .en_i,
        .config_valid_i, .config_counter_i, .config_ready_o,
        .spin_valid_i, .spin_i, .spin_ready_o,
        .weight_valid_i, .weight_i, .weight_ready_o,
        .energy_valid_o, .energy_o, .energy_ready_i,
        .accum_overflow_o
    );

    // empty slices take a beat on every port, nothing offered yet
    a_reset_state: assert property (@(posedge clk)
        $rose(arst_n_i) |-> config_ready_o && spin_ready_o && weight_ready_o &&
                            !energy_valid_o && !accum_overflow_o)
    else begin
        $display("%0t ports not ready or outputs not idle after reset", $time);
        err_cnt++;
    end

    a_energy_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        energy_valid_o && energy_ready_i |-> energy_o == exp_energy)
    else begin
        $display("[FAIL] %0t energy_o expected %0d got %0d", $time,
                 $sampled(exp_energy), $sampled(energy_o));
        err_cnt++;
    end

    a_overflow_value: assert property (@(posedge clk) disable iff (!arst_n_i)
        energy_valid_o |-> accum_overflow_o == exp_ovf)
    else begin
        $display("[FAIL] %0t accum_overflow_o expected %0b got %0b", $time,
                 $sampled(exp_ovf), $sampled(accum_overflow_o));
        err_cnt++;
    end

    a_overflow_clear: assert property (@(posedge clk) disable iff (!arst_n_i)
        energy_valid_o && energy_ready_i |=> !accum_overflow_o)
    else begin
        $display("%0t overflow flag still set after the energy handshake", $time);
        err_cnt++;
    end

    a_hold_output: assert property (@(posedge clk) disable iff (!arst_n_i)
        energy_valid_o && !energy_ready_i |=> energy_valid_o && $stable(energy_o))
    else begin
        $display("%0t energy output dropped or changed while stalled", $time);
        err_cnt++;
    end

    // the config slice may take one beat, then it must stay full
    a_config_blocked: assert property (@(posedge clk) disable iff (!arst_n_i)
        config_valid_i && config_ready_o && energy_valid_o && !energy_ready_i
        |=> !config_ready_o)
    else begin
        $display("%0t config beat accepted while the energy output was stalled", $time);
        err_cnt++;
    end

    // port transfer, slice, accumulate: valid is seen two edges later
    a_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(energy_valid_o) |-> $past(weight_valid_i && weight_ready_o && last_tag, 2))
    else begin
        $display("%0t energy_valid_o did not rise 2 cycles after the last weight", $time);
        err_cnt++;
    end

    a_extra_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        extra_phase |-> !weight_ready_o)
    else begin
        $display("%0t a weight beat beyond the last row was accepted", $time);
        err_cnt++;
    end

    a_enable_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        !en_i && $past(!en_i) |-> $stable(energy_o) && $stable(energy_valid_o))
    else begin
        $display("%0t energy output moved while en_i was low", $time);
        err_cnt++;
    end

    a_enable_block: assert property (@(posedge clk) disable iff (!arst_n_i)
        !en_i && $past(!en_i && weight_valid_i) |-> !weight_ready_o)
    else begin
        $display("%0t weight beats kept flowing while en_i was low", $time);
        err_cnt++;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic port_ready(input int ch);
        case (ch)
            0:       return config_ready_o;
            1:       return spin_ready_o;
            default: return weight_ready_o;
        endcase
    endfunction

    // s_i * (sum_j J_ij * s_j + h_i * scale), summed with 32-bit wrap
    function automatic expect_t model_energy(input int last);
        int      row;
        int      coup;
        int      acc;
        longint  wide;
        expect_t e;
        acc   = 0;
        e.ovf = 1'b0;
        for (int i = 0; i <= last; i++) begin
            row = int'($signed(w_mem[i].hbias)) * int'(w_mem[i].hscaling);
            for (int j = 0; j < ising_pkg::NUM_SPINS; j++) begin
                coup = int'($signed(w_mem[i].j_row[j]));
                row  = spin_vec[j] ? row + coup : row - coup;
            end
            if (!spin_vec[i]) row = -row;
            wide = longint'(acc) + longint'(row);
            if (wide != longint'(int'(wide))) e.ovf = 1'b1; // left the 32-bit range
            acc = int'(wide);
        end
        e.energy = acc;
        return e;
    endfunction

    task automatic make_random();
        for (int i = 0; i < ising_pkg::NUM_SPINS; i++) begin
            for (int j = 0; j < ising_pkg::NUM_SPINS; j++) begin
                w_mem[i].j_row[j] = 4'($random(seed));
            end
            w_mem[i].hbias    = 4'($random(seed));
            w_mem[i].hscaling = 5'($random(seed));
        end
        spin_vec = 16'($random(seed));
    endtask

    task automatic make_extreme();
        for (int i = 0; i < ising_pkg::NUM_SPINS; i++) begin
            for (int j = 0; j < ising_pkg::NUM_SPINS; j++) begin
                w_mem[i].j_row[j] = 4'h8; // -8
            end
            w_mem[i].hbias    = 4'h8;
            w_mem[i].hscaling = 5'd31;
        end
        spin_vec = '1;
    endtask

    task automatic push_expected(input expect_t e);
        if (exp_q.size() == 0) exp_head = e;
        exp_q.push_back(e);
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic wait_accept(input int ch);
        #1;
        while (!port_ready(ch)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic send_config(input int last, input int max_gap);
        repeat (rand_below(max_gap + 1)) @(negedge clk);
        config_counter_i = 4'(last);
        config_valid_i   = 1'b1;
        wait_accept(0);
        config_valid_i = 1'b0;
    endtask

    task automatic send_spin(input int max_gap);
        repeat (rand_below(max_gap + 1)) @(negedge clk);
        spin_i       = spin_vec;
        spin_valid_i = 1'b1;
        wait_accept(1);
        spin_valid_i = 1'b0;
    endtask

    task automatic send_weight_beat(input ising_pkg::weight_word_t w, input logic tag);
        weight_i       = w;
        last_tag       = tag;
        weight_valid_i = 1'b1;
        wait_accept(2);
        last_tag = 1'b0;
        wgt_sent++;
    endtask

    task automatic send_weights(input int last, input int max_gap);
        int gap;
        for (int i = 0; i <= last; i++) begin
            gap = rand_below(max_gap + 1);
            if (gap > 0) begin
                weight_valid_i = 1'b0;
                repeat (gap) @(negedge clk);
            end
            send_weight_beat(w_mem[i], i == last);
        end
        weight_valid_i = 1'b0;
    endtask

    task automatic receive_energy(input int stall);
        while (!energy_valid_o) @(negedge clk);
        repeat (stall) @(negedge clk); // back-pressure
        energy_ready_i = 1'b1;
        @(negedge clk);
        energy_ready_i = 1'b0;
        void'(exp_q.pop_front());
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    endtask

    task automatic pulse_enable_low();
        int start;
        start = wgt_sent;
        while (wgt_sent < start + 4) @(negedge clk);
        en_i = 1'b0;
        repeat (10) @(negedge clk);
        en_i = 1'b1;
    endtask

    // next_cfg >= 0 offers the following config beat while this energy is stalled
    task automatic run_computation(input int last, input int max_gap, input int stall,
                                   input bit cfg_sent, input int next_cfg, input bit drop_en);
        push_expected(model_energy(last));
        fork
            begin
                if (!cfg_sent) send_config(last, max_gap);
            end
            send_spin(max_gap);
            send_weights(last, max_gap);
            receive_energy(stall);
            begin
                if (next_cfg >= 0) begin
                    while (!energy_valid_o) @(negedge clk);
                    send_config(next_cfg, 0);
                end
            end
            begin
                if (drop_en) pulse_enable_low();
            end
        join
    endtask

    task automatic report_test(input string name);
        repeat (2) @(negedge clk); // let the last checks fire
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "errors");
        err_before = err_cnt;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int last_a;
        int last_b;
        arst_n_i         = 1'b0;
        en_i             = 1'b1;
        config_valid_i   = 1'b0;
        config_counter_i = '0;
        spin_valid_i     = 1'b0;
        spin_i           = '0;
        weight_valid_i   = 1'b0;
        weight_i         = '0;
        energy_ready_i   = 1'b0;
        err_before       = 0;
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);

        make_random();
        run_computation(15, 0, 0, 1'b0, -1, 1'b0);
        report_test("full 16-row run");

        // rows 3 and 4 become a later 2-row computation, its row 0 arrives early
        make_random();
        b0 = w_mem[3];
        b1 = w_mem[4];
        push_expected(model_energy(2));
        fork
            send_config(2, 0);
            send_spin(0);
            begin
                send_weights(2, 0);
                send_weight_beat(b0, 1'b0);
                weight_valid_i = 1'b0;
            end
            receive_energy(1);
        join
        w_mem[0] = b0;
        w_mem[1] = b1;
        spin_vec = 16'($random(seed));
        push_expected(model_energy(1));
        fork
            begin
                extra_phase = 1'b1;
                repeat (6) @(negedge clk);
                extra_phase = 1'b0;
                send_config(1, 0);
                send_spin(0);
            end
            begin
                send_weight_beat(b1, 1'b1);
                weight_valid_i = 1'b0;
            end
            receive_energy(0);
        join
        report_test("short config of 3 rows");

        last_a = 1 + rand_below(15);
        last_b = 1 + rand_below(15);
        make_random();
        run_computation(last_a, 3, 4, 1'b0, last_b, 1'b0);
        make_random();
        run_computation(last_b, 3, 2, 1'b1, -1, 1'b0);
        for (int k = 0; k < 2; k++) begin
            make_random();
            run_computation(1 + rand_below(15), 2, rand_below(5), 1'b0, -1, 1'b0);
        end
        report_test("random gaps and back-pressure");

        for (int k = 0; k < 3; k++) begin
            make_extreme();
            run_computation(15, 0, 3, 1'b0, -1, 1'b0);
        end
        report_test("extreme couplings and overflow flag");

        make_random();
        run_computation(7, 0, 0, 1'b0, -1, 1'b0);
        report_test("latency from last weight");

        make_random();
        run_computation(15, 1, 0, 1'b0, -1, 1'b1);
        report_test("enable low in mid run");

        $display("summary: %0d tests run, %0d checks failed", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// free running clock for the testbench, 10 ns period
// starts low at time zero

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #5 clk_o = ~clk_o; // half period

endmodule

`default_nettype wire

// ==== source/energy_monitor.sv ====
// Ising energy monitor for one 16-spin configuration
// every input channel passes a one-stage register slice
// energy_valid_o rises 2 cycles after the last weight transfer at the ports
// en_i low freezes the FSM and counters, an offered energy beat stays offered

`timescale 1ns/1ps
`default_nettype none

module energy_monitor (
    input  wire logic                                clk_i,
    input  wire logic                                arst_n_i,
    input  wire logic                                en_i,

    input  wire logic                                config_valid_i,
    input  wire logic [ising_pkg::IDX_BIT-1:0]       config_counter_i, // last row index
    output logic                                     config_ready_o,

    input  wire logic                                spin_valid_i,
    input  wire logic [ising_pkg::NUM_SPINS-1:0]     spin_i,
    output logic                                     spin_ready_o,

    input  wire logic                                weight_valid_i,
    input  wire ising_pkg::weight_word_t             weight_i,
    output logic                                     weight_ready_o,

    output logic                                     energy_valid_o,
    output logic signed [ising_pkg::TOTAL_E_BIT-1:0] energy_o,
    input  wire logic                                energy_ready_i,

    output logic                                     accum_overflow_o
);

    // inner side of the pipes
    logic                             cfg_valid, cfg_ready;
    logic [ising_pkg::IDX_BIT-1:0]    cfg_last;
    logic                             spin_valid, spin_ready;
    logic [ising_pkg::NUM_SPINS-1:0]  spin_data;
    logic                             wgt_valid, wgt_ready;
    ising_pkg::weight_word_t          wgt_data;

    logic                                    cfg_hs, spin_hs, wgt_hs, energy_hs;
    logic [ising_pkg::IDX_BIT-1:0]           row_idx;
    logic                                    row_pending;
    logic [ising_pkg::NUM_SPINS-1:0]         spins_cached;
    logic                                    row_spin;
    logic signed [ising_pkg::LOCAL_E_BIT-1:0] local_energy;
    logic                                    done;

    assign cfg_hs    = cfg_valid && cfg_ready;
    assign spin_hs   = spin_valid && spin_ready;
    assign wgt_hs    = wgt_valid && wgt_ready;
    assign energy_hs = energy_valid_o && energy_ready_i;

    bp_pipe #(.DATA_W(ising_pkg::IDX_BIT)) u_pipe_config (
        .clk_i, .arst_n_i,
        .valid_i(config_valid_i), .data_i(config_counter_i), .ready_o(config_ready_o),
        .valid_o(cfg_valid), .data_o(cfg_last), .ready_i(cfg_ready)
    );

    bp_pipe #(.DATA_W(ising_pkg::NUM_SPINS)) u_pipe_spin (
        .clk_i, .arst_n_i,
        .valid_i(spin_valid_i), .data_i(spin_i), .ready_o(spin_ready_o),
        .valid_o(spin_valid), .data_o(spin_data), .ready_i(spin_ready)
    );

    bp_pipe #(.DATA_W(ising_pkg::WEIGHT_W)) u_pipe_weight (
        .clk_i, .arst_n_i,
        .valid_i(weight_valid_i), .data_i(weight_i), .ready_o(weight_ready_o),
        .valid_o(wgt_valid), .data_o(wgt_data), .ready_i(wgt_ready)
    );

    monitor_ctrl u_ctrl (
        .clk_i, .arst_n_i, .en_i,
        .config_valid_i(cfg_valid), .config_ready_o(cfg_ready),
        .spin_valid_i(spin_valid), .spin_ready_o(spin_ready),
        .weight_valid_i(wgt_valid), .weight_ready_o(wgt_ready),
        .row_pending_i(row_pending), .done_i(done),
        .energy_valid_o, .energy_ready_i
    );

    row_counter u_rows (
        .clk_i, .arst_n_i, .en_i,
        .config_load_i(cfg_hs), .config_last_i(cfg_last),
        .recount_i(spin_hs), .step_i(wgt_hs),
        .row_idx_o(row_idx), .row_pending_o(row_pending)
    );

    spin_cache u_spins (
        .clk_i, .arst_n_i, .en_i,
        .load_i(spin_hs), .spins_i(spin_data), .row_idx_i(row_idx),
        .spins_o(spins_cached), .row_spin_o(row_spin)
    );

    partial_energy_calc u_calc (
        .spins_i(spins_cached), .row_spin_i(row_spin),
        .weight_i(wgt_data), .energy_o(local_energy)
    );

    // last_i is high once the counter has no row left
    energy_accumulator u_accum (
        .clk_i, .arst_n_i, .en_i,
        .clear_i(energy_hs), .add_i(wgt_hs), .last_i(!row_pending),
        .data_i(local_energy), .accum_o(energy_o),
        .overflow_o(accum_overflow_o), .done_o(done)
    );

endmodule

`default_nettype wire

// ==== source/energy_accumulator.sv ====
// signed running sum of the partial energies
// overflow is sticky until clear_i, the sum wraps on overflow
// done_o is high the cycle after an add once last_i reports no pending row

`timescale 1ns/1ps
`default_nettype none

module energy_accumulator (
    input  wire logic                                clk_i,
    input  wire logic                                arst_n_i,
    input  wire logic                                en_i,
    input  wire logic                                clear_i,
    input  wire logic                                add_i,
    input  wire logic                                last_i,
    input  wire logic signed [ising_pkg::LOCAL_E_BIT-1:0] data_i,
    output logic signed [ising_pkg::TOTAL_E_BIT-1:0] accum_o,
    output logic                                     overflow_o,
    output logic                                     done_o
);

    logic signed [ising_pkg::TOTAL_E_BIT-1:0] accum_q;
    logic signed [ising_pkg::TOTAL_E_BIT-1:0] addend;
    logic signed [ising_pkg::TOTAL_E_BIT-1:0] sum;
    logic                                     wrap;
    logic                                     ovf_q;
    logic                                     add_q; // an add happened last cycle

    assign addend = ising_pkg::TOTAL_E_BIT'(data_i); // sign extended
    assign sum    = accum_q + addend;
    // same operand signs, different result sign
    assign wrap   = (accum_q[$high(accum_q)] == addend[$high(addend)]) &&
                    (sum[$high(sum)] != accum_q[$high(accum_q)]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            accum_q <= '0;
            ovf_q   <= 1'b0;
            add_q   <= 1'b0;
        end else if (clear_i) begin
            accum_q <= '0;
            ovf_q   <= 1'b0;
            add_q   <= 1'b0;
        end else if (en_i) begin
            add_q <= add_i;
            if (add_i) begin
                accum_q <= sum;
                if (wrap) ovf_q <= 1'b1;
            end
        end
    end

    assign accum_o    = accum_q;
    assign overflow_o = ovf_q;
    assign done_o     = add_q && last_i;

endmodule

`default_nettype wire

// ==== source/partial_energy_calc.sv ====
// partial energy of one row, purely combinational
// result = s_i * (sum_j J_ij * s_j + h_i * scale)
// worst case magnitude is about 380, well inside LOCAL_E_BIT

`timescale 1ns/1ps
`default_nettype none

module partial_energy_calc (
    input  wire logic [ising_pkg::NUM_SPINS-1:0]   spins_i,
    input  wire logic                              row_spin_i,
    input  wire ising_pkg::weight_word_t           weight_i,
    output logic signed [ising_pkg::LOCAL_E_BIT-1:0] energy_o
);

    localparam int W = ising_pkg::LOCAL_E_BIT;

    logic signed [W-1:0] coup;
    logic signed [W-1:0] j_sum;
    logic signed [W-1:0] bias_term;
    logic signed [W-1:0] row_sum;

    // spin of 0 means -1, so the coupling is subtracted
    always_comb begin
        j_sum = '0;
        coup  = '0;
        for (int j = 0; j < ising_pkg::NUM_SPINS; j++) begin
            coup = W'($signed(weight_i.j_row[j]));
            if (spins_i[j]) begin
                j_sum = j_sum + coup;
            end else begin
                j_sum = j_sum - coup;
            end
        end
    end

    // scale is unsigned, zero bit keeps it positive in the signed product
    assign bias_term = W'($signed(weight_i.hbias)) *
                       W'($signed({1'b0, weight_i.hscaling}));

    assign row_sum  = j_sum + bias_term;
    assign energy_o = row_spin_i ? row_sum : -row_sum;

endmodule

`default_nettype wire

// ==== source/spin_cache.sv ====
// holds the spin vector of the current computation
// row_spin_o follows row_idx_i combinationally

`timescale 1ns/1ps
`default_nettype none

module spin_cache (
    input  wire logic                            clk_i,
    input  wire logic                            arst_n_i,
    input  wire logic                            en_i,
    input  wire logic                            load_i,
    input  wire logic [ising_pkg::NUM_SPINS-1:0] spins_i,
    input  wire logic [ising_pkg::IDX_BIT-1:0]   row_idx_i,
    output logic [ising_pkg::NUM_SPINS-1:0]      spins_o,
    output logic                                 row_spin_o
);

    logic [ising_pkg::NUM_SPINS-1:0] spins_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spins_q <= '0;
        end else if (en_i && load_i) begin
            spins_q <= spins_i;
        end
    end

    assign spins_o    = spins_q;
    assign row_spin_o = spins_q[row_idx_i]; // spin of the row being summed

endmodule

`default_nettype wire

// ==== source/row_counter.sv ====
// row index for the weight stream
// config_last_i is the index of the last row, so last+1 rows are processed
// row_pending_o drops on the step that retires the last row

`timescale 1ns/1ps
`default_nettype none

module row_counter (
    input  wire logic                          clk_i,
    input  wire logic                          arst_n_i,
    input  wire logic                          en_i,
    input  wire logic                          config_load_i,
    input  wire logic [ising_pkg::IDX_BIT-1:0] config_last_i,
    input  wire logic                          recount_i,
    input  wire logic                          step_i,
    output logic [ising_pkg::IDX_BIT-1:0]      row_idx_o,
    output logic                               row_pending_o
);

    logic [ising_pkg::IDX_BIT-1:0] last_q;
    logic [ising_pkg::IDX_BIT-1:0] idx_q;
    logic                          pending_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q    <= '0;
            idx_q     <= '0;
            pending_q <= 1'b0;
        end else if (en_i) begin
            if (config_load_i) last_q <= config_last_i;
            if (recount_i) begin
                idx_q     <= '0;
                pending_q <= 1'b1;
            end else if (step_i) begin
                idx_q <= idx_q + 1'b1;
                if (idx_q == last_q) pending_q <= 1'b0; // last row retired
            end
        end
    end

    assign row_idx_o     = idx_q;
    assign row_pending_o = pending_q;

    a_step_pending: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        step_i |-> row_pending_o
    );

endmodule

`default_nettype wire

// ==== source/monitor_ctrl.sv ====
// sequencing FSM: config, then spins, then weight rows, then energy out
// inner readies are low while en_i is low
// an accepted energy beat is always honoured, even with en_i low

`timescale 1ns/1ps
`default_nettype none

module monitor_ctrl (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic en_i,
    input  wire logic config_valid_i,
    output logic      config_ready_o,
    input  wire logic spin_valid_i,
    output logic      spin_ready_o,
    input  wire logic weight_valid_i,
    output logic      weight_ready_o,
    input  wire logic row_pending_i,
    input  wire logic done_i,
    output logic      energy_valid_o,
    input  wire logic energy_ready_i
);

    ising_pkg::ctrl_state_t state_q, state_d;
    logic config_hs;
    logic spin_hs;
    logic energy_hs;

    assign config_ready_o = en_i && (state_q == ising_pkg::IDLE);
    assign spin_ready_o   = en_i && (state_q == ising_pkg::CONFIG_DONE);
    assign weight_ready_o = en_i && (state_q == ising_pkg::COMPUTE) && row_pending_i;

    // valid rises together with done, held in OUTPUT
    assign energy_valid_o = (state_q == ising_pkg::OUTPUT) ||
                            ((state_q == ising_pkg::COMPUTE) && done_i);

    assign config_hs = config_valid_i && config_ready_o;
    assign spin_hs   = spin_valid_i && spin_ready_o;
    assign energy_hs = energy_valid_o && energy_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ising_pkg::IDLE:        if (config_hs) state_d = ising_pkg::CONFIG_DONE;
            ising_pkg::CONFIG_DONE: if (spin_hs) state_d = ising_pkg::COMPUTE;
            ising_pkg::COMPUTE:     if (done_i) state_d = ising_pkg::OUTPUT;
            default:                state_d = state_q; // OUTPUT waits for the consumer
        endcase
        if (energy_hs) begin
            state_d = ising_pkg::IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ising_pkg::IDLE;
        end else if (en_i || energy_hs) begin
            state_q <= state_d;
        end
    end

    a_one_ready: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({config_ready_o, spin_ready_o, weight_ready_o})
    );

    // once the last row is retired no further weight beat may slip in
    a_no_weight_at_done: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        done_i |-> !(weight_valid_i && weight_ready_o)
    );

endmodule

`default_nettype wire

// ==== source/bp_pipe.sv ====
// single register slice for a valid/ready channel
// full throughput, one cycle from input transfer to output valid
// data register has no reset, only the valid bit is cleared

`timescale 1ns/1ps
`default_nettype none

module bp_pipe #(
    parameter int DATA_W = 8
) (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              valid_i,
    input  wire logic [DATA_W-1:0] data_i,
    output logic                   ready_o,
    output logic                   valid_o,
    output logic [DATA_W-1:0]      data_o,
    input  wire logic              ready_i
);

    logic              valid_q;
    logic [DATA_W-1:0] data_q;

    // deeper pipes are not supported here
    if (ising_pkg::PIPES != 1) begin : g_depth_check
        $error("bp_pipe only implements a depth of one");
    end

    assign ready_o = !valid_q || ready_i; // empty or draining this cycle
    assign valid_o = valid_q;
    assign data_o  = data_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    // a stalled beat must not change under the consumer
    a_stall_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    );

endmodule

`default_nettype wire

// ==== source/ising_pkg.sv ====
// shared widths and types for the 16-spin Ising energy monitor
// a spin bit of 1 is +1 and 0 is -1
// couplings and bias are signed two's complement, the bias scale is unsigned
// PIPES is fixed at one, bp_pipe is written for that depth only

`default_nettype none

package ising_pkg;

    localparam int NUM_SPINS   = 16;
    localparam int BIT_J       = 4;  // signed coupling
    localparam int BIT_H       = 4;  // signed bias
    localparam int SCALE_BIT   = 5;  // unsigned bias scale
    localparam int IDX_BIT     = 4;  // row index, covers NUM_SPINS rows
    localparam int LOCAL_E_BIT = 16; // partial energy of one row
    localparam int TOTAL_E_BIT = 32; // running total
    localparam int PIPES       = 1;  // register stages per input channel

    // one weight beat, row couplings in the upper bits
    typedef struct packed {
        logic [NUM_SPINS-1:0][BIT_J-1:0] j_row;    // J_i0 in the lowest nibble
        logic signed [BIT_H-1:0]         hbias;
        logic [SCALE_BIT-1:0]            hscaling;
    } weight_word_t;

    localparam int WEIGHT_W = $bits(weight_word_t);

    typedef enum logic [1:0] {
        IDLE,        // waiting for a config beat
        CONFIG_DONE, // waiting for the spin vector
        COMPUTE,     // taking weight rows
        OUTPUT       // energy offered downstream
    } ctrl_state_t;

endpackage

`default_nettype wire
